/* hw/aluPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the small RV32I integer ALU.
// Holds the word and shift amount widths, the 3-bit function codes
// (RISC-V funct3 encoding) and the kinds of shift the shifter runs.
// Modules import it with a wildcard import inside their body.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aluPkg;

  localparam int dataWidth  = 32;  // Operand and result width
  localparam int shamtWidth = 5;   // Shift amount, low bits of in2

  // Operation codes, same values as funct3 of the RV32I OP group
  typedef enum logic [2:0] {
    funcAdd  = 3'b000,  // ADD, or SUB with funcQual
    funcSll  = 3'b001,  // Shift left logical
    funcSlt  = 3'b010,  // Set less than, signed
    funcSltu = 3'b011,  // Set less than, unsigned
    funcXor  = 3'b100,
    funcSrl  = 3'b101,  // SRL, or SRA with funcQual
    funcOr   = 3'b110,
    funcAnd  = 3'b111
  } aluFunc;

  // Direction and fill of the iterative shifter
  typedef enum logic [1:0] {
    shiftLeft       = 2'b00,  // Zero fill from the right
    shiftRightLogic = 2'b01,  // Zero fill from the left
    shiftRightArith = 2'b10   // Sign fill from the left
  } shiftKind;

  // True for the two codes that go through the shifter
  function automatic logic isShiftFunc(aluFunc func);
    return (func == funcSll) || (func == funcSrl);
  endfunction

  // Shift kind selected by a shift code and its qualifier
  function automatic shiftKind kindOf(aluFunc func, logic funcQual);
    if (func == funcSll) begin
      return shiftLeft;
    end
    return funcQual ? shiftRightArith : shiftRightLogic;
  endfunction

endpackage

/* hw/shiftCtrlIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control bundle of the iterative shifter.
// Links the sequencing FSM, the shift amount counter and the working
// register. Instantiate once in the top level and hand each block the
// modport that matches its role.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface shiftCtrlIf;
  import aluPkg::*;

  logic     load;       // Take new operand and amount this cycle
  logic     step;       // Advance the shift by one step
  logic     stepFour;   // Current step moves four bits, not one
  shiftKind kind;       // Latched shift direction and fill
  logic     countZero;  // No shift amount left

  modport fsm (
    output load, step, kind,
    input  countZero
  );

  modport counter (
    input  load, step,
    output stepFour, countZero
  );

  modport shifter (
    input load, step, stepFour, kind
  );

endinterface

/* hw/aluSeqFsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer for the multi-cycle shifts.
// A wr strobe with SLL or SRL/SRA loads the shifter and records the kind
// of shift. Steps are requested until the counter reports zero, and busy
// is high for as long as steps remain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aluSeqFsm (
  input  logic          clk,
  input  logic          reset,
  input  logic          wr,        // Start strobe, one cycle
  input  aluPkg::aluFunc func,
  input  logic          funcQual,  // Selects SRA over SRL
  output logic          busy,
  shiftCtrlIf.fsm       ctrl
);
  import aluPkg::*;

  typedef enum logic {
    stateIdle,
    stateShifting
  } seqState;

  seqState  state;
  seqState  stateNext;
  logic     shiftActive;  // Shifting with amount left
  shiftKind kindNext;

  // Load goes out in the wr cycle itself, no clock in between
  assign ctrl.load = wr && isShiftFunc(func);
  assign kindNext  = kindOf(func, funcQual);

  assign shiftActive = (state == stateShifting) && !ctrl.countZero;
  assign ctrl.step   = shiftActive;
  assign busy        = shiftActive;  // Low at once for amount zero

  always_comb begin
    stateNext = state;
    case (state)
      stateIdle: begin
        if (ctrl.load) begin
          stateNext = stateShifting;
        end
      end
      stateShifting: begin
        if (ctrl.load) begin
          stateNext = stateShifting;  // Restart, a wr always wins
        end else if (ctrl.countZero) begin
          stateNext = stateIdle;      // Last step done
        end
      end
      default: stateNext = stateIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= stateIdle;
      ctrl.kind <= shiftLeft;
    end else begin
      state <= stateNext;
      if (ctrl.load) begin
        ctrl.kind <= kindNext;  // Held for the whole shift
      end
    end
  end

endmodule

/* hw/shiftCounter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Remaining shift amount of the iterative shifter.
// Loaded from the low bits of in2, counted down on each step. With the
// two-stage option it takes steps of four while more than four remain,
// and tells the working register which step size is in use.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module shiftCounter #(
  parameter bit twoStageShifter = 1'b0  // Allow steps of four bits
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [aluPkg::shamtWidth-1:0] amount,  // Shift amount to load
  shiftCtrlIf.counter                   ctrl
);
  import aluPkg::*;

  localparam logic [shamtWidth-1:0] stepOne  = shamtWidth'(1);
  localparam logic [shamtWidth-1:0] stepFour = shamtWidth'(4);

  logic [shamtWidth-1:0] count;     // Bits still to shift
  logic [shamtWidth-1:0] stepSize;

  // Big steps only while they cannot overshoot
  assign ctrl.stepFour  = twoStageShifter && (count > stepFour);
  assign ctrl.countZero = (count == '0);
  assign stepSize       = ctrl.stepFour ? stepFour : stepOne;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ctrl.load) begin
      count <= amount;             // Reload, also during a running shift
    end else if (ctrl.step) begin
      count <= count - stepSize;   // Never below zero
    end
  end

endmodule

/* hw/shiftRegister.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Working register of the iterative shifter.
// Takes in1 on load, then moves one or four bits per step, left or
// right, with zero or sign fill as the latched kind demands.
// Its value is the shift result once the counter has reached zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module shiftRegister (
  input  logic                         clk,
  input  logic [aluPkg::dataWidth-1:0] operand,  // Value to be shifted
  output logic [aluPkg::dataWidth-1:0] value,
  shiftCtrlIf.shifter                  ctrl
);
  import aluPkg::*;

  logic                 fill;       // Bit shifted in from the left
  logic [dataWidth-1:0] shiftOne;
  logic [dataWidth-1:0] shiftFour;
  logic [dataWidth-1:0] valueNext;

  assign fill = (ctrl.kind == shiftRightArith) && value[dataWidth-1];

  always_comb begin
    case (ctrl.kind)
      shiftRightLogic, shiftRightArith: begin
        shiftOne  = {fill, value[dataWidth-1:1]};
        shiftFour = {{4{fill}}, value[dataWidth-1:4]};
      end
      default: begin               // Left shift
        shiftOne  = {value[dataWidth-2:0], 1'b0};
        shiftFour = {value[dataWidth-5:0], 4'b0000};
      end
    endcase
  end

  always_comb begin
    valueNext = value;
    if (ctrl.load) begin
      valueNext = operand;
    end else if (ctrl.step) begin
      valueNext = ctrl.stepFour ? shiftFour : shiftOne;
    end
  end

  // Payload only, meaningful after the first load
  always_ff @(posedge clk) begin
    value <= valueNext;
  end

endmodule

/* hw/arithLogicUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational part of the ALU.
// One 33-bit subtract serves SUB, SLT and SLTU; XOR, OR and AND are
// plain gates. Shift codes pass the shifter value through. The sum on
// aPlusB is always valid, for address computation.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module arithLogicUnit (
  input  logic [aluPkg::dataWidth-1:0] in1,
  input  logic [aluPkg::dataWidth-1:0] in2,
  input  aluPkg::aluFunc              func,
  input  logic                         funcQual,    // SUB instead of ADD
  input  logic [aluPkg::dataWidth-1:0] shiftValue,  // From the shifter
  output logic [aluPkg::dataWidth-1:0] result,
  output logic [aluPkg::dataWidth-1:0] aPlusB
);
  import aluPkg::*;

  localparam int msb = dataWidth - 1;

  logic [dataWidth:0]   diff;          // in1 - in2 with borrow on top
  logic                 lessUnsigned;
  logic                 lessSigned;
  logic [dataWidth-1:0] sltWord;
  logic [dataWidth-1:0] sltuWord;

  assign aPlusB = in1 + in2;

  // Borrow is set exactly when in1 < in2 unsigned
  assign diff         = {1'b0, in1} - {1'b0, in2};
  assign lessUnsigned = diff[dataWidth];

  // Differing signs: the negative one is smaller
  assign lessSigned = (in1[msb] ^ in2[msb]) ? in1[msb] : diff[dataWidth];

  assign sltWord  = {{(dataWidth-1){1'b0}}, lessSigned};
  assign sltuWord = {{(dataWidth-1){1'b0}}, lessUnsigned};

  always_comb begin
    case (func)
      funcAdd:  result = funcQual ? diff[dataWidth-1:0] : aPlusB;
      funcSlt:  result = sltWord;
      funcSltu: result = sltuWord;
      funcXor:  result = in1 ^ in2;
      funcOr:   result = in1 | in2;
      funcAnd:  result = in1 & in2;
      funcSll:  result = shiftValue;  // Valid once busy has fallen
      funcSrl:  result = shiftValue;  // SRL and SRA alike
      default:  result = aPlusB;
    endcase
  end

endmodule

/* hw/smallAlu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Small RV32I integer ALU, top level.
// Combinational operations answer in the same cycle; shifts start on a
// wr strobe and are done when busy falls. Operands and func must stay
// stable until then. twoStageShifter trades area for faster shifts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module smallAlu #(
  parameter bit twoStageShifter = 1'b0  // Four-bit steps for long shifts
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [aluPkg::dataWidth-1:0] in1,
  input  logic [aluPkg::dataWidth-1:0] in2,
  input  aluPkg::aluFunc              func,
  input  logic                         funcQual,  // SUB / SRA select
  input  logic                         wr,        // Start strobe
  output logic [aluPkg::dataWidth-1:0] result,
  output logic                         busy,      // Shift in progress
  output logic [aluPkg::dataWidth-1:0] aPlusB     // Address adder
);
  import aluPkg::*;

  logic [dataWidth-1:0] shiftValue;  // Working register contents

  shiftCtrlIf shiftCtrl ();

  aluSeqFsm seqFsm (
    .clk      (clk),
    .reset    (reset),
    .wr       (wr),
    .func     (func),
    .funcQual (funcQual),
    .busy     (busy),
    .ctrl     (shiftCtrl.fsm)
  );

  shiftCounter #(
    .twoStageShifter (twoStageShifter)
  ) counter (
    .clk    (clk),
    .reset  (reset),
    .amount (in2[shamtWidth-1:0]),  // RV32I uses the low five bits
    .ctrl   (shiftCtrl.counter)
  );

  shiftRegister shifter (
    .clk     (clk),
    .operand (in1),
    .value   (shiftValue),
    .ctrl    (shiftCtrl.shifter)
  );

  arithLogicUnit alu (
    .in1        (in1),
    .in2        (in2),
    .func       (func),
    .funcQual   (funcQual),
    .shiftValue (shiftValue),
    .result     (result),
    .aPlusB     (aPlusB)
  );

endmodule

/* bench/smallAluTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the small RV32I ALU.
// Drives random and corner operands through all functions, waits for
// busy to fall on shifts and compares against a reference model.
// twoStageShifter is set from the command line of the simulator build.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module smallAluTb #(
  parameter bit twoStageShifter = 1'b0  // Four-bit steps in the DUT
);
  import aluPkg::*;

  localparam int numIdle    = 4;   // Quiet cycles after reset
  localparam int numComb    = 60;  // Random ADD/SUB/XOR/OR/AND
  localparam int numCmpVec  = 8;   // Corner pairs, SLT and SLTU each
  localparam int numCmpRand = 20;  // Random SLT/SLTU
  localparam int numShift   = 30;  // Random SLL/SRL/SRA
  localparam int numZero    = 3;   // Shifts by zero
  localparam int numChain   = 6;   // Back-to-back shifts
  localparam int numOps     = numIdle + numComb + 2 * numCmpVec + numCmpRand
                              + numShift + numZero + numChain;
  localparam int cycleLimit = numOps * 40;

  logic                 clk;
  logic                 reset;
  logic [dataWidth-1:0] in1;
  logic [dataWidth-1:0] in2;
  aluFunc               func;
  logic                 funcQual;
  logic                 wr;
  logic [dataWidth-1:0] result;
  logic                 busy;
  logic [dataWidth-1:0] aPlusB;

  logic   checkResult;  // Compare result whenever busy is low
  logic   expectIdle;   // busy must stay low
  logic   busyCheck;    // Measure busy length of the running shift
  int     busyExpect;
  int     errorCount;
  int     checkCount;
  int     cycleCount;
  integer seed;

  // Corner operands for the compares, signs and extremes
  logic [31:0] cmpA [numCmpVec] = '{32'h0000_0000, 32'h0000_0005, 32'h8000_0000,
                                    32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff,
                                    32'h0000_0001, 32'h7fff_ffff};
  logic [31:0] cmpB [numCmpVec] = '{32'h0000_0000, 32'h0000_0005, 32'h7fff_ffff,
                                    32'h8000_0000, 32'h8000_0000, 32'h0000_0001,
                                    32'hffff_ffff, 32'h7fff_ffff};

  smallAlu #(
    .twoStageShifter (twoStageShifter)
  ) UUT (
    .clk      (clk),
    .reset    (reset),
    .in1      (in1),
    .in2      (in2),
    .func     (func),
    .funcQual (funcQual),
    .wr       (wr),
    .result   (result),
    .busy     (busy),
    .aPlusB   (aPlusB)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // RV32I semantics, shift amount from the low five bits of b
  function automatic logic [31:0] refAlu(input logic [31:0] a, input logic [31:0] b,
                                         input aluFunc f, input logic q);
    logic [4:0]  shamt;
    logic [31:0] value;
    shamt = b[4:0];
    case (f)
      funcAdd:  value = q ? a - b : a + b;
      funcSll:  value = a << shamt;
      funcSlt:  value = {31'b0, $signed(a) < $signed(b)};
      funcSltu: value = {31'b0, a < b};
      funcXor:  value = a ^ b;
      funcSrl: begin
        if (q) begin
          value = $signed(a) >>> shamt;  // Sign fill
        end else begin
          value = a >> shamt;
        end
      end
      funcOr:   value = a | b;
      funcAnd:  value = a & b;
      default:  value = '0;
    endcase
    return value;
  endfunction

  // Steps of four while more than four remain, then single steps
  function automatic int shiftCycles(input logic [4:0] amount);
    int remaining;
    int cycles;
    remaining = int'(amount);
    cycles = 0;
    while (remaining > 0) begin
      if (twoStageShifter && remaining > 4) begin
        remaining = remaining - 4;
      end else begin
        remaining = remaining - 1;
      end
      cycles++;
    end
    return cycles;
  endfunction

  task automatic applyComb(input logic [31:0] a, input logic [31:0] b,
                           input aluFunc f, input logic q);
    @(posedge clk);
    #10;
    in1         = a;
    in2         = b;
    func        = f;
    funcQual    = q;
    wr          = 1'b0;
    checkResult = 1'b1;  // Checked just after the next edge
    expectIdle  = 1'b1;
    busyCheck   = 1'b0;
  endtask

  // Chained start goes out in the first cycle with busy low
  task automatic runShift(input logic [31:0] a, input logic [4:0] amount,
                          input aluFunc f, input logic q, input logic chained);
    logic [31:0] upper;
    upper = $random(seed);  // Upper in2 bits must be ignored
    if (!chained) begin
      @(posedge clk);
      #10;
    end
    in1         = a;
    in2         = {upper[31:5], amount};
    func        = f;
    funcQual    = q;
    wr          = 1'b1;
    checkResult = 1'b1;  // Next sample already sees the loaded shifter
    expectIdle  = 1'b0;
    busyExpect  = shiftCycles(amount);
    busyCheck   = 1'b1;
    @(posedge clk);
    #10;
    wr = 1'b0;
    while (busy) begin
      @(posedge clk);  // Watchdog bounds this wait
      #10;
    end
  endtask

  // Output checker, samples after the edge and before new inputs
  always @(posedge clk) begin : compareOutputs
    logic [31:0] expectedSum;
    logic [31:0] expectedResult;
    int          busyRun;
    logic        busyDone;
    #5;
    if (!reset) begin
      expectedSum = in1 + in2;
      checkCount++;
      assert (aPlusB === expectedSum) else begin
        errorCount++;
        $display("FAILED aPlusB: got %h expected %h", aPlusB, expectedSum);
      end
      if (expectIdle) begin
        checkCount++;
        assert (busy === 1'b0) else begin
          errorCount++;
          $display("FAILED busy: got %h expected %h", busy, 1'b0);
        end
      end
      if (checkResult && !busy) begin
        expectedResult = refAlu(in1, in2, func, funcQual);
        checkCount++;
        assert (result === expectedResult) else begin
          errorCount++;
          $display("FAILED result: got %h expected %h (in1 %h in2 %h func %h qual %h)",
                   result, expectedResult, in1, in2, func, funcQual);
        end
      end
      if (wr) begin
        busyRun  = 0;     // Shift loaded on this edge
        busyDone = 1'b0;
      end
      if (busyCheck && !busyDone) begin
        if (busy) begin
          busyRun++;
        end else begin
          checkCount++;
          assert (busyRun == busyExpect) else begin
            errorCount++;
            $display("FAILED busy cycles: got %h expected %h", busyRun, busyExpect);
          end
          busyDone = 1'b1;  // One length check per shift
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: test still running after %0d cycles", cycleLimit);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] a;
    logic [4:0]  amt;
    seed        = 32'h601b_e89e;
    reset       = 1'b1;
    in1         = '0;
    in2         = '0;
    func        = funcAdd;
    funcQual    = 1'b0;
    wr          = 1'b0;
    checkResult = 1'b0;
    expectIdle  = 1'b0;
    busyCheck   = 1'b0;
    busyExpect  = 0;
    errorCount  = 0;
    checkCount  = 0;
    repeat (8) @(posedge clk);
    #10;
    reset      = 1'b0;
    expectIdle = 1'b1;  // No wr yet, busy stays low
    repeat (numIdle) @(posedge clk);

    for (int i = 0; i < numComb; i++) begin
      r = $random(seed);
      case (i % 5)
        0:       applyComb($random(seed), $random(seed), funcAdd, r[0]);  // ADD or SUB
        1:       applyComb($random(seed), $random(seed), funcAdd, 1'b1);
        2:       applyComb($random(seed), $random(seed), funcXor, r[0]);
        3:       applyComb($random(seed), $random(seed), funcOr, r[0]);
        default: applyComb($random(seed), $random(seed), funcAnd, r[0]);
      endcase
    end

    for (int k = 0; k < numCmpVec; k++) begin
      applyComb(cmpA[k], cmpB[k], funcSlt, 1'b0);
      applyComb(cmpA[k], cmpB[k], funcSltu, 1'b0);
    end
    for (int i = 0; i < numCmpRand; i++) begin
      applyComb($random(seed), $random(seed), (i % 2 == 0) ? funcSlt : funcSltu, 1'b0);
    end

    for (int i = 0; i < numShift; i++) begin
      r   = $random(seed);
      amt = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];  // Amounts 1 to 31
      a   = $random(seed);
      case (i % 3)
        0:       runShift(a, amt, funcSll, 1'b0, 1'b0);
        1:       runShift(a, amt, funcSrl, 1'b0, 1'b0);
        default: runShift(a, amt, funcSrl, 1'b1, 1'b0);  // SRA
      endcase
    end

    runShift(32'h8765_4321, 5'd0, funcSll, 1'b0, 1'b0);
    runShift(32'hf0f0_0f0f, 5'd0, funcSrl, 1'b0, 1'b0);
    runShift(32'h8000_0001, 5'd0, funcSrl, 1'b1, 1'b0);

    // New wr while the FSM still sits in the shifting state
    runShift(32'h1234_5678, 5'd7, funcSll, 1'b0, 1'b1);
    runShift(32'h9abc_def0, 5'd31, funcSrl, 1'b1, 1'b1);
    runShift(32'hfedc_ba98, 5'd3, funcSrl, 1'b0, 1'b1);
    runShift(32'h8000_0000, 5'd12, funcSrl, 1'b1, 1'b1);
    runShift(32'h0000_0001, 5'd31, funcSll, 1'b0, 1'b1);
    runShift(32'hc000_0000, 5'd5, funcSrl, 1'b0, 1'b1);

    @(posedge clk);
    #10;
    checkResult = 1'b0;
    busyCheck   = 1'b0;
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
hw/aluPkg.sv
hw/shiftCtrlIf.sv
hw/aluSeqFsm.sv
hw/shiftCounter.sv
hw/shiftRegister.sv
hw/arithLogicUnit.sv
hw/smallAlu.sv
bench/smallAluTb.sv

/* Makefile */
# Verilator flow for the small RV32I ALU
# Example: make sim TWO_STAGE=1

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= smallAluTb
RTL_TOP    ?= smallAlu
TWO_STAGE  ?= 0
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
BUILD_OPTS ?= --binary --timing --assert -j 0
RTL_FILES  ?= hw/aluPkg.sv hw/shiftCtrlIf.sv hw/aluSeqFsm.sv hw/shiftCounter.sv \
              hw/shiftRegister.sv hw/arithLogicUnit.sv hw/smallAlu.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(BUILD_OPTS) --top-module $(TB_TOP) \
	  -GtwoStageShifter=$(TWO_STAGE) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -qx "Simulation PASSED" $(LOG); then \
	  echo "Result: pass"; \
	else \
	  echo "Result: fail, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
